/* Makefile */
# Verilator build for the SIMD register-file unit

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_simd_rf
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

# Static checks of the whole project
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, pass only when the pass line appears
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
source/simd_pkg.sv
source/lane_cmd_if.sv
source/regfile_2r1w_zero.sv
source/cmd_dispatch.sv
source/vector_lane.sv
source/result_collect.sv
source/simd_rf_top.sv
sim/tb_simd_rf.sv

/* sim/tb_simd_rf.sv */
/*
  Testbench for the SIMD register-file unit
  Reference model per lane, directed and random commands, checked results
*/

`timescale 1ns/1ns

module tb_simd_rf;

  import simd_pkg::*;

  localparam int num_lanes  = default_num_lanes;
  localparam int data_nbits = default_data_nbits;
  localparam int num_regs   = default_num_regs;
  localparam int addr_nbits = $clog2(num_regs);

  logic                            clk = 1'b0;
  logic                            reset;
  logic                            cmd_valid;
  simd_op_e                        cmd_op;
  logic [addr_nbits-1:0]           cmd_rd;
  logic [addr_nbits-1:0]           cmd_rs1;
  logic [addr_nbits-1:0]           cmd_rs2;
  logic [data_nbits-1:0]           cmd_imm;
  logic [num_lanes-1:0]            cmd_lane_mask;
  logic                            result_valid;
  logic [num_lanes*data_nbits-1:0] result_data;
  logic [data_nbits-1:0]           result_sum;

  // One model register file per lane
  logic [data_nbits-1:0] model [num_lanes][num_regs];

  // Expected reads in issue order
  logic [num_lanes*data_nbits-1:0] exp_data_q [$];
  logic [data_nbits-1:0]           exp_sum_q [$];
  int                              exp_edge_q [$];

  int     edge_count = 0;
  integer seed = 32'h72c1;

  simd_rf_top uut (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_rd        (cmd_rd),
    .cmd_rs1       (cmd_rs1),
    .cmd_rs2       (cmd_rs2),
    .cmd_imm       (cmd_imm),
    .cmd_lane_mask (cmd_lane_mask),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .result_sum    (result_sum)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // Rising edges counted for latency checks
  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // r0 reads zero in every lane
  function automatic logic [data_nbits-1:0] model_reg(input int lane,
                                                      input logic [addr_nbits-1:0] addr);
    return (addr == '0) ? '0 : model[lane][addr];
  endfunction

  // Applies one command to every masked lane and returns 1 for op_read
  function automatic logic apply_command(
    input  simd_op_e                        op,
    input  logic [addr_nbits-1:0]           rd,
    input  logic [addr_nbits-1:0]           rs1,
    input  logic [addr_nbits-1:0]           rs2,
    input  logic [data_nbits-1:0]           imm,
    input  logic [num_lanes-1:0]            mask,
    output logic [num_lanes*data_nbits-1:0] exp_data,
    output logic [data_nbits-1:0]           exp_sum
  );
    logic [data_nbits-1:0] a;
    logic [data_nbits-1:0] b;
    exp_data = '0;
    exp_sum  = '0;
    for (int lane = 0; lane < num_lanes; lane++) begin
      a = model_reg(lane, rs1);
      b = model_reg(lane, rs2);
      if (mask[lane]) begin
        // Sums wrap at data_nbits through the target width
        case (op)
          op_li:   model[lane][rd] = imm;
          op_add:  model[lane][rd] = a + b;
          op_sub:  model[lane][rd] = a - b;
          op_and:  model[lane][rd] = a & b;
          op_xor:  model[lane][rd] = a ^ b;
          op_addi: model[lane][rd] = a + imm;
          op_read: begin
            exp_data[lane*data_nbits +: data_nbits] = a;
            exp_sum = exp_sum + a;
          end
          default: ;
        endcase
      end
    end
    return op == op_read;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic abort_run;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_data(input logic [num_lanes*data_nbits-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch at %0t: result_data got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sum(input logic [data_nbits-1:0] got, exp);
    if (got !== exp) begin
      $display("mismatch at %0t: result_sum got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input int got, exp);
    if (got != exp) begin
      $display("mismatch at %0t: result_valid edge got %0d expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (reset) begin
      // Nothing to compare while in reset
    end else if (exp_edge_q.size() != 0 && edge_count > exp_edge_q[0]) begin
      $display("No result arrived for an op_read due at edge %0d", exp_edge_q[0]);
      abort_run();
    end else if (result_valid && exp_edge_q.size() == 0) begin
      $display("result_valid went high at %0t with no op_read pending", $time);
      abort_run();
    end else if (result_valid) begin
      check_latency(edge_count, exp_edge_q.pop_front());
      check_data(result_data, exp_data_q.pop_front());
      check_sum(result_sum, exp_sum_q.pop_front());
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // One command driven 1 ns after the edge and sampled at the next one
  task automatic issue(input simd_op_e op, input logic [addr_nbits-1:0] rd, rs1, rs2,
                       input logic [data_nbits-1:0] imm, input logic [num_lanes-1:0] mask);
    logic [num_lanes*data_nbits-1:0] exp_data;
    logic [data_nbits-1:0]           exp_sum;
    @(posedge clk);
    #1;
    cmd_valid     = 1'b1;
    cmd_op        = op;
    cmd_rd        = rd;
    cmd_rs1       = rs1;
    cmd_rs2       = rs2;
    cmd_imm       = imm;
    cmd_lane_mask = mask;
    if (apply_command(op, rd, rs1, rs2, imm, mask, exp_data, exp_sum)) begin
      exp_data_q.push_back(exp_data);
      exp_sum_q.push_back(exp_sum);
      // Sampled at the next edge with the result two edges later
      exp_edge_q.push_back(edge_count + 3);
    end
  endtask

  task automatic idle;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  function automatic logic [addr_nbits-1:0] rand_addr;
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[addr_nbits-1:0];
  endfunction

  function automatic logic [data_nbits-1:0] rand_data;
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[data_nbits-1:0];
  endfunction

  function automatic logic [num_lanes-1:0] rand_mask;
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[num_lanes-1:0];
  endfunction

  // Loads two operands, runs op into r5 and reads it back
  // For op_addi b is the immediate
  // The immediate and r4 are always bitwise inverses
  task automatic alu_case(input simd_op_e op, input logic [data_nbits-1:0] a, b);
    logic [data_nbits-1:0] rs2_val;
    rs2_val = (op == op_addi) ? ~b : b;
    issue(op_li, 4'd3, 4'd0, 4'd0, a, 4'b1111);
    issue(op_li, 4'd4, 4'd0, 4'd0, rs2_val, 4'b1111);
    issue(op, 4'd5, 4'd3, 4'd4, ~rs2_val, 4'b1111);
    issue(op_read, 4'd0, 4'd5, 4'd0, '0, 4'b1111);
  endtask

  initial begin
    logic [31:0] rnd;
    int          wait_cycles;
    reset         = 1'b1;
    cmd_valid     = 1'b0;
    cmd_op        = op_nop;
    cmd_rd        = '0;
    cmd_rs1       = '0;
    cmd_rs2       = '0;
    cmd_imm       = '0;
    cmd_lane_mask = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Give every register of every lane its own value
    for (int lane = 0; lane < num_lanes; lane++) begin
      for (int r = 1; r < num_regs; r++) begin
        issue(op_li, addr_nbits'(r), 4'd0, 4'd0, rand_data(), num_lanes'(1 << lane));
      end
    end

    // Load under the full mask and read back
    issue(op_li, 4'd1, 4'd0, 4'd0, 32'hc000_0001, 4'b1111);
    issue(op_read, 4'd0, 4'd1, 4'd0, '0, 4'b1111);

    // r0 ignores writes
    issue(op_li, 4'd0, 4'd0, 4'd0, 32'hdead_beef, 4'b1111);
    issue(op_read, 4'd0, 4'd0, 4'd0, '0, 4'b1111);

    // Single-lane loads followed by partial-mask reads
    for (int lane = 0; lane < num_lanes; lane++) begin
      issue(op_li, 4'd2, 4'd0, 4'd0, rand_data(), num_lanes'(1 << lane));
    end
    issue(op_read, 4'd0, 4'd2, 4'd0, '0, 4'b0101);
    issue(op_read, 4'd0, 4'd2, 4'd0, '0, 4'b1010);
    issue(op_read, 4'd0, 4'd2, 4'd0, '0, 4'b0000);

    // ALU operations with random operands and at the wrap point
    alu_case(op_add, rand_data(), rand_data());
    alu_case(op_sub, rand_data(), rand_data());
    alu_case(op_and, rand_data(), rand_data());
    alu_case(op_xor, rand_data(), rand_data());
    alu_case(op_addi, rand_data(), rand_data());
    alu_case(op_add, 32'hffff_fff0, 32'h0000_0020);
    alu_case(op_sub, 32'h0000_0001, 32'h0000_0002);
    alu_case(op_addi, 32'hffff_ffff, 32'h0000_0002);

    // Dependent chain on consecutive cycles
    issue(op_li, 4'd6, 4'd0, 4'd0, 32'h0000_0011, 4'b1111);
    issue(op_addi, 4'd7, 4'd6, 4'd0, 32'hffff_fff8, 4'b1111);
    issue(op_add, 4'd8, 4'd7, 4'd7, '0, 4'b1111);
    issue(op_read, 4'd0, 4'd8, 4'd0, '0, 4'b1111);
    issue(op_sub, 4'd9, 4'd8, 4'd6, '0, 4'b0111);
    issue(op_read, 4'd0, 4'd9, 4'd0, '0, 4'b1111);
    issue(op_xor, 4'd10, 4'd9, 4'd7, '0, 4'b1111);
    issue(op_read, 4'd0, 4'd10, 4'd0, '0, 4'b1111);
    issue(op_read, 4'd0, 4'd10, 4'd0, '0, 4'b1001);

    // Random mix with idle cycles
    for (int n = 0; n < 400; n++) begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'd0) begin
        idle();
      end else begin
        issue(simd_op_e'(rnd[6:4]), rand_addr(), rand_addr(), rand_addr(), rand_data(),
              rand_mask());
      end
    end
    idle();

    // Drain the pending reads
    wait_cycles = 0;
    while (exp_edge_q.size() != 0 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_edge_q.size() != 0) begin
      $display("Timed out with %0d reads still pending", exp_edge_q.size());
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* source/cmd_dispatch.sv */
/*
  Command dispatcher
  Registers each command and decodes it into per-lane write enables and a read strobe
*/

`timescale 1ns/1ns

module cmd_dispatch #(
  parameter int num_lanes  = 4,
  parameter int data_nbits = 32,
  parameter int num_regs   = 16
) (
  input  logic                        clk,
  input  logic                        reset,

  // Command in, one-cycle strobe with fields
  input  logic                        cmd_valid,
  input  simd_pkg::simd_op_e          cmd_op,
  input  logic [$clog2(num_regs)-1:0] cmd_rd,
  input  logic [$clog2(num_regs)-1:0] cmd_rs1,
  input  logic [$clog2(num_regs)-1:0] cmd_rs2,
  input  logic [data_nbits-1:0]       cmd_imm,
  input  logic [num_lanes-1:0]        cmd_lane_mask,

  // Decoded command out to the lanes
  lane_cmd_if.dispatch                cmd
);

  import simd_pkg::*;

  logic is_write;
  logic is_read;

  // Opcode class decode
  always_comb begin
    is_write = 1'b0;
    is_read  = 1'b0;
    case (cmd_op)
      op_li, op_add, op_sub, op_and, op_xor, op_addi: is_write = 1'b1;
      op_read: is_read = 1'b1;
      // op_nop sets neither class
      default: is_write = 1'b0;
    endcase
  end

  // Strobes, cleared on reset and on idle cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.wr_mask   <= '0;
      cmd.rd_strobe <= 1'b0;
    end else begin
      cmd.wr_mask   <= (cmd_valid && is_write) ? cmd_lane_mask : '0;
      cmd.rd_strobe <= cmd_valid && is_read;
    end
  end

  // Payload fields, loaded with each accepted command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      cmd.alu_op    <= cmd_op;
      cmd.rd        <= cmd_rd;
      cmd.rs1       <= cmd_rs1;
      cmd.rs2       <= cmd_rs2;
      cmd.imm       <= cmd_imm;
      cmd.lane_mask <= cmd_lane_mask;
    end
  end

endmodule

/* source/lane_cmd_if.sv */
/*
  Decoded command bus
  Carries one command from the dispatcher to every lane and the collector
*/

`timescale 1ns/1ns

interface lane_cmd_if #(
  parameter int num_lanes  = 4,
  parameter int data_nbits = 32,
  parameter int num_regs   = 16
);

  import simd_pkg::*;

  localparam int addr_nbits = $clog2(num_regs);

  // Operation and operand fields
  simd_op_e              alu_op;
  logic [addr_nbits-1:0] rd;
  logic [addr_nbits-1:0] rs1;
  logic [addr_nbits-1:0] rs2;
  logic [data_nbits-1:0] imm;

  // Per-lane write enables and read strobe
  logic [num_lanes-1:0]  wr_mask;
  logic                  rd_strobe;
  // Registered lane mask of the command
  logic [num_lanes-1:0]  lane_mask;

  modport dispatch (output alu_op, rd, rs1, rs2, imm, wr_mask, rd_strobe, lane_mask);
  modport lane     (input  alu_op, rd, rs1, rs2, imm, wr_mask, rd_strobe, lane_mask);

endinterface

/* source/regfile_2r1w_zero.sv */
/*
  Register file with two read ports and one write port
  Register 0 always reads as zero
*/

`timescale 1ns/1ns

module regfile_2r1w_zero #(
  parameter int data_nbits = 32,
  parameter int num_regs   = 16
) (
  input  logic                        clk,
  input  logic                        reset,

  // Read port 0, combinational
  input  logic [$clog2(num_regs)-1:0] read_addr0,
  output logic [data_nbits-1:0]       read_data0,

  // Read port 1, combinational
  input  logic [$clog2(num_regs)-1:0] read_addr1,
  output logic [data_nbits-1:0]       read_data1,

  // Write port, sampled on the rising edge
  input  logic                        write_en,
  input  logic [$clog2(num_regs)-1:0] write_addr,
  input  logic [data_nbits-1:0]       write_data
);

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------

  // Contents are undefined until written
  logic [data_nbits-1:0] rfile [num_regs];

  // ------------------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------------------

  // Address 0 gives zero whatever was written there
  assign read_data0 = (read_addr0 == '0) ? '0 : rfile[read_addr0];
  assign read_data1 = (read_addr1 == '0) ? '0 : rfile[read_addr1];

  // ------------------------------------------------------------------------
  // Write port
  // ------------------------------------------------------------------------

  // Writes are blocked while reset is high
  // A write here is seen by the reads in the very next cycle
  always_ff @(posedge clk) begin
    if (write_en && !reset) begin
      rfile[write_addr] <= write_data;
    end
  end

endmodule

/* source/result_collect.sv */
/*
  Result collector
  Masks and packs lane read data, and sums the masked lanes
*/

`timescale 1ns/1ns

module result_collect #(
  parameter int num_lanes  = 4,
  parameter int data_nbits = 32
) (
  input  logic                            clk,
  input  logic                            reset,

  // Command bus, only lane_mask is read here
  lane_cmd_if.lane                        cmd,

  // Per-lane read results
  input  logic [num_lanes-1:0]            lane_valid,
  input  logic [data_nbits-1:0]           lane_data [num_lanes],

  // Packed result, lane 0 in the low bits
  output logic                            result_valid,
  output logic [num_lanes*data_nbits-1:0] result_data,
  output logic [data_nbits-1:0]           result_sum
);

  logic [num_lanes-1:0]            mask_q;
  logic [num_lanes*data_nbits-1:0] packed_data;
  logic [data_nbits-1:0]           lane_sum;

  // Delay the mask by one stage to line up with lane_valid
  always_ff @(posedge clk) begin
    mask_q <= cmd.lane_mask;
  end

  // ------------------------------------------------------------------------
  // Pack and sum
  // ------------------------------------------------------------------------

  // Lanes outside the mask give zero and add nothing
  always_comb begin
    packed_data = '0;
    lane_sum    = '0;
    for (int i = 0; i < num_lanes; i++) begin
      if (mask_q[i]) begin
        packed_data[i*data_nbits +: data_nbits] = lane_data[i];
        lane_sum = lane_sum + lane_data[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------------------

  // All lanes pulse together, any one of them marks a result
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= |lane_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (|lane_valid) begin
      result_data <= packed_data;
      result_sum  <= lane_sum;
    end
  end

endmodule

/* source/simd_pkg.sv */
/*
  SIMD register-file unit shared definitions
  Command opcodes and the default sizes of the top level
*/

package simd_pkg;

  // ------------------------------------------------------------------------
  // Command opcodes
  // ------------------------------------------------------------------------

  // Every arithmetic result wraps modulo 2**data_nbits
  // Write class is op_li through op_addi, read class is op_read only
  typedef enum logic [2:0] {
    // Nothing happens, no write and no result
    op_nop  = 3'd0,
    // rd = imm
    op_li   = 3'd1,
    // rd = rs1 + rs2
    op_add  = 3'd2,
    // rd = rs1 - rs2
    op_sub  = 3'd3,
    // rd = rs1 & rs2
    op_and  = 3'd4,
    // rd = rs1 ^ rs2
    op_xor  = 3'd5,
    // rd = rs1 + imm
    op_addi = 3'd6,
    // Return rs1 of every lane, nothing written
    op_read = 3'd7
  } simd_op_e;

  // ------------------------------------------------------------------------
  // Default sizes
  // ------------------------------------------------------------------------

  // Number of vector lanes
  parameter int default_num_lanes  = 4;

  // Width of one lane's data word
  parameter int default_data_nbits = 32;

  // Registers per lane, r0 included
  parameter int default_num_regs   = 16;

endpackage

/* source/simd_rf_top.sv */
/*
  SIMD register-file unit, top level
  Dispatcher, a row of identical vector lanes and a result collector
*/

`timescale 1ns/1ns

module simd_rf_top #(
  parameter int num_lanes  = simd_pkg::default_num_lanes,
  parameter int data_nbits = simd_pkg::default_data_nbits,
  parameter int num_regs   = simd_pkg::default_num_regs
) (
  input  logic                            clk,
  input  logic                            reset,

  // Command, one per cycle at most
  input  logic                            cmd_valid,
  input  simd_pkg::simd_op_e              cmd_op,
  input  logic [$clog2(num_regs)-1:0]     cmd_rd,
  input  logic [$clog2(num_regs)-1:0]     cmd_rs1,
  input  logic [$clog2(num_regs)-1:0]     cmd_rs2,
  input  logic [data_nbits-1:0]           cmd_imm,
  input  logic [num_lanes-1:0]            cmd_lane_mask,

  // Result of op_read, two edges after the command
  output logic                            result_valid,
  output logic [num_lanes*data_nbits-1:0] result_data,
  output logic [data_nbits-1:0]           result_sum
);

  // Lane results towards the collector
  logic [num_lanes-1:0]  lane_valid;
  logic [data_nbits-1:0] lane_data [num_lanes];

  // Decoded command bus
  lane_cmd_if #(
    .num_lanes  (num_lanes),
    .data_nbits (data_nbits),
    .num_regs   (num_regs)
  ) cmd_bus ();

  // ------------------------------------------------------------------------
  // Dispatcher
  // ------------------------------------------------------------------------

  cmd_dispatch #(
    .num_lanes  (num_lanes),
    .data_nbits (data_nbits),
    .num_regs   (num_regs)
  ) dispatch (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_rd        (cmd_rd),
    .cmd_rs1       (cmd_rs1),
    .cmd_rs2       (cmd_rs2),
    .cmd_imm       (cmd_imm),
    .cmd_lane_mask (cmd_lane_mask),
    .cmd           (cmd_bus)
  );

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------

  for (genvar i = 0; i < num_lanes; i++) begin : lanes
    vector_lane #(
      .lane_index (i),
      .data_nbits (data_nbits),
      .num_regs   (num_regs)
    ) lane (
      .clk        (clk),
      .reset      (reset),
      .cmd        (cmd_bus),
      .lane_valid (lane_valid[i]),
      .lane_data  (lane_data[i])
    );
  end

  // Collector drives the top-level result
  result_collect #(
    .num_lanes  (num_lanes),
    .data_nbits (data_nbits)
  ) collect (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd_bus),
    .lane_valid   (lane_valid),
    .lane_data    (lane_data),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_sum   (result_sum)
  );

endmodule

/* source/vector_lane.sv */
/*
  One vector lane
  Private register file, small integer ALU and a registered read result
*/

`timescale 1ns/1ns

module vector_lane #(
  parameter int lane_index = 0,
  parameter int data_nbits = 32,
  parameter int num_regs   = 16
) (
  input  logic                  clk,
  input  logic                  reset,

  // Decoded command, shared by all lanes
  lane_cmd_if.lane              cmd,

  // Read result towards the collector
  output logic                  lane_valid,
  output logic [data_nbits-1:0] lane_data
);

  import simd_pkg::*;

  logic [data_nbits-1:0] rs1_data;
  logic [data_nbits-1:0] rs2_data;
  logic [data_nbits-1:0] alu_result;
  logic                  wr_en;

  // ------------------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------------------

  // This lane writes only when its own mask bit is set
  assign wr_en = cmd.wr_mask[lane_index];

  regfile_2r1w_zero #(
    .data_nbits (data_nbits),
    .num_regs   (num_regs)
  ) rf (
    .clk        (clk),
    .reset      (reset),
    .read_addr0 (cmd.rs1),
    .read_data0 (rs1_data),
    .read_addr1 (cmd.rs2),
    .read_data1 (rs2_data),
    .write_en   (wr_en),
    .write_addr (cmd.rd),
    .write_data (alu_result)
  );

  // ------------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------------

  // Combinational, result written at the next edge
  // Sums and differences drop the carry out
  always_comb begin
    case (cmd.alu_op)
      op_li:   alu_result = cmd.imm;
      op_add:  alu_result = rs1_data + rs2_data;
      op_sub:  alu_result = rs1_data - rs2_data;
      op_and:  alu_result = rs1_data & rs2_data;
      op_xor:  alu_result = rs1_data ^ rs2_data;
      op_addi: alu_result = rs1_data + cmd.imm;
      // Never written for op_nop or op_read
      default: alu_result = rs1_data;
    endcase
  end

  // ------------------------------------------------------------------------
  // Read result
  // ------------------------------------------------------------------------

  // One-cycle pulse for every op_read
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= cmd.rd_strobe;
    end
  end

  // rs1 value captured alongside the pulse
  always_ff @(posedge clk) begin
    if (cmd.rd_strobe) begin
      lane_data <= rs1_data;
    end
  end

endmodule
